// ==== rr_wrapper_settings.svh ====
`ifndef RR_WRAPPER_SETTINGS_SVH
`define RR_WRAPPER_SETTINGS_SVH

//////////////////////////////////////////////////
// datapath sizes
//////////////////////////////////////////////////
// payload bits carried by one channel strobe
`define RR_DATA_W 16
// number of host-to-cl write channels
`define RR_NUM_CHAN 2
// id field of a log word, ids 2 and 3 name no channel
`define RR_CHAN_ID_W 2
// entries held by each recorder fifo
`define RR_FIFO_DEPTH 4
// fill level at which almost-full goes high
`define RR_ALMFUL_LVL 3

//////////////////////////////////////////////////
// control register map
//////////////////////////////////////////////////
`define RR_CSR_ADDR_W 2
`define RR_CSR_DATA_W 32
`define RR_CSR_MODE 2'd0
`define RR_CSR_STATE 2'd1
`define RR_CSR_COUNT 2'd2

`endif

// ==== rr_pkg.sv ====
`include "rr_wrapper_settings.svh"

package rr_pkg;

  //////////////////////////////////////////////////
  // channel and log types
  //////////////////////////////////////////////////
  // one host-to-cl transaction, valid is the strobe
  typedef struct packed {
    logic                  valid;
    logic [`RR_DATA_W-1:0] data;
  } rr_chan_t;

  // one log entry, tagged with the channel it came from
  typedef struct packed {
    logic [`RR_CHAN_ID_W-1:0] chan;
    logic [`RR_DATA_W-1:0]    data;
  } rr_log_word_t;

  //////////////////////////////////////////////////
  // csr types
  //////////////////////////////////////////////////
  // record_en sits in bit 0, replay_en in bit 1
  typedef struct packed {
    logic replay_en;
    logic record_en;
  } rr_mode_t;

  // sticky error bits, ovf in [1:0] and bad_chan in bit 2
  typedef struct packed {
    logic                    bad_chan;
    logic [`RR_NUM_CHAN-1:0] ovf;
  } rr_oneoff_t;

  // live fifo levels
  typedef struct packed {
    logic [`RR_NUM_CHAN-1:0] almful;
  } rr_rt_t;

  // oneoff in the low bits, rt above it
  typedef struct packed {
    rr_rt_t     rt;
    rr_oneoff_t oneoff;
  } rr_state_t;

endpackage

// ==== rr_csrs.sv ====
`timescale 1ns/1ps
`include "rr_wrapper_settings.svh"

module rr_csrs (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      i_csr_wr,
  input  logic [`RR_CSR_ADDR_W-1:0] i_csr_addr,
  input  logic [`RR_CSR_DATA_W-1:0] i_csr_wdata,
  input  logic [`RR_NUM_CHAN-1:0]   i_ovf,
  input  logic [`RR_NUM_CHAN-1:0]   i_almful,
  input  logic                      i_bad_chan,
  input  logic                      i_log_xfer,
  output logic [`RR_CSR_DATA_W-1:0] o_csr_rdata,
  output rr_pkg::rr_mode_t          o_mode
);

  localparam int DATA_W   = `RR_CSR_DATA_W;
  localparam int MODE_W   = $bits(rr_pkg::rr_mode_t);
  localparam int STATE_W  = $bits(rr_pkg::rr_state_t);
  localparam int ONEOFF_W = $bits(rr_pkg::rr_oneoff_t);

  rr_pkg::rr_mode_t   mode_q;
  rr_pkg::rr_state_t  state_q;
  rr_pkg::rr_oneoff_t oneoff_in;
  rr_pkg::rr_oneoff_t oneoff_clr;
  logic [DATA_W-1:0]  count_q;
  logic [DATA_W-1:0]  rdata_q;
  logic               wr_mode;
  logic               wr_state;

  // write decode
  assign wr_mode  = i_csr_wr && (i_csr_addr == `RR_CSR_MODE);
  assign wr_state = i_csr_wr && (i_csr_addr == `RR_CSR_STATE);

  // error events collected from the datapath this cycle
  assign oneoff_in.ovf      = i_ovf;
  assign oneoff_in.bad_chan = i_bad_chan;

  // ones written to the state word clear the matching sticky bits
  assign oneoff_clr = wr_state ? rr_pkg::rr_oneoff_t'(i_csr_wdata[ONEOFF_W-1:0]) : '0;

  //////////////////////////////////////////////////
  // mode register
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      mode_q <= '0;
    end else if (wr_mode) begin
      mode_q <= rr_pkg::rr_mode_t'(i_csr_wdata[MODE_W-1:0]);
    end
  end

  assign o_mode = mode_q;

  //////////////////////////////////////////////////
  // state register
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state_q <= '0;
    end else begin
      // a new event wins over a clear in the same cycle
      state_q.oneoff <= (state_q.oneoff & ~oneoff_clr) | oneoff_in;
      // real-time part just tracks the fifos
      state_q.rt.almful <= i_almful;
    end
  end

  // log words handed to the outgoing stream
  always_ff @(posedge clk) begin
    if (!rstn) begin
      count_q <= '0;
    end else if (i_log_xfer) begin
      count_q <= count_q + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // read port
  //////////////////////////////////////////////////
  // data returns one cycle after the address
  always_ff @(posedge clk) begin
    if (!rstn) begin
      rdata_q <= '0;
    end else begin
      case (i_csr_addr)
        `RR_CSR_MODE:  rdata_q <= {{(DATA_W-MODE_W){1'b0}}, mode_q};
        `RR_CSR_STATE: rdata_q <= {{(DATA_W-STATE_W){1'b0}}, state_q};
        `RR_CSR_COUNT: rdata_q <= count_q;
        default:       rdata_q <= '0;
      endcase
    end
  end

  assign o_csr_rdata = rdata_q;

endmodule

// ==== rr_channel_recorder.sv ====
`timescale 1ns/1ps
`include "rr_wrapper_settings.svh"

module rr_channel_recorder #(
  parameter int CHAN_ID = 0
) (
  input  logic                 clk,
  input  logic                 rstn,
  input  rr_pkg::rr_chan_t     i_cl_chan,
  input  logic                 i_record_en,
  input  logic                 i_pop,
  output rr_pkg::rr_log_word_t o_entry,
  output logic                 o_empty,
  output logic                 o_almful,
  output logic                 o_ovf
);

  localparam int DEPTH = `RR_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int ID_W  = `RR_CHAN_ID_W;

  // only the payload is stored, the tag is constant per instance
  logic [`RR_DATA_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [CNT_W-1:0]      count_q;
  logic                  push_req;
  logic                  full;
  logic                  push;
  logic                  pop;

  // every strobe seen by the cl is logged while recording
  assign push_req = i_cl_chan.valid && i_record_en;
  assign full     = (count_q == CNT_W'(DEPTH));
  assign push     = push_req && !full;
  assign pop      = i_pop && !o_empty;

  //////////////////////////////////////////////////
  // circular buffer
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr_q] <= i_cl_chan.data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // fill level moves only when exactly one side is active
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // head of the fifo, tagged for the merger
  assign o_entry.chan = ID_W'(CHAN_ID);
  assign o_entry.data = mem[rd_ptr_q];

  assign o_empty  = (count_q == '0);
  assign o_almful = (count_q >= CNT_W'(`RR_ALMFUL_LVL));
  // the dropped strobe is flagged in the cycle it arrives
  assign o_ovf    = push_req && full;

endmodule

// ==== rr_log_merger.sv ====
`timescale 1ns/1ps
`include "rr_wrapper_settings.svh"

module rr_log_merger (
  input  logic                    clk,
  input  logic                    rstn,
  input  rr_pkg::rr_log_word_t    i_entry [`RR_NUM_CHAN],
  input  logic [`RR_NUM_CHAN-1:0] i_empty,
  input  logic                    i_log_ready,
  output logic [`RR_NUM_CHAN-1:0] o_pop,
  output logic                    o_log_valid,
  output rr_pkg::rr_log_word_t    o_log_word,
  output logic                    o_log_xfer
);

  localparam int N     = `RR_NUM_CHAN;
  localparam int SEL_W = (N > 1) ? $clog2(N) : 1;

  logic [SEL_W-1:0]     last_q;
  logic [SEL_W-1:0]     pick;
  logic                 found;
  logic                 valid_q;
  rr_pkg::rr_log_word_t word_q;
  logic                 xfer;
  logic                 load;

  //////////////////////////////////////////////////
  // round-robin pick
  //////////////////////////////////////////////////
  // search starts one past the last granted fifo
  always_comb begin
    int idx;
    found = 1'b0;
    pick  = last_q;
    idx   = 0;
    for (int k = 1; k <= N; k++) begin
      idx = (int'(last_q) + k) % N;
      if (!found && !i_empty[idx]) begin
        found = 1'b1;
        pick  = SEL_W'(idx);
      end
    end
  end

  // output slot frees up when empty or when its word leaves
  assign xfer = valid_q && i_log_ready;
  assign load = found && (!valid_q || i_log_ready);

  always_comb begin
    o_pop = '0;
    if (load) begin
      o_pop[pick] = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////
  // the held word counts as one extra slot in front of the fifos
  always_ff @(posedge clk) begin
    if (!rstn) begin
      valid_q <= 1'b0;
      last_q  <= '0;
    end else if (load) begin
      valid_q <= 1'b1;
      last_q  <= pick;
    end else if (xfer) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      word_q <= i_entry[pick];
    end
  end

  assign o_log_valid = valid_q;
  assign o_log_word  = word_q;
  assign o_log_xfer  = xfer;

endmodule

// ==== rr_replay_decoder.sv ====
`timescale 1ns/1ps
`include "rr_wrapper_settings.svh"

module rr_replay_decoder (
  input  logic                 clk,
  input  logic                 rstn,
  input  rr_pkg::rr_chan_t     i_sh_chan [`RR_NUM_CHAN],
  input  logic                 i_replay_en,
  input  logic                 i_rply_valid,
  input  rr_pkg::rr_log_word_t i_rply_word,
  output logic                 o_rply_ready,
  output rr_pkg::rr_chan_t     o_cl_chan [`RR_NUM_CHAN],
  output logic                 o_bad_chan
);

  localparam int N = `RR_NUM_CHAN;

  logic [N-1:0]          valid_q;
  logic [`RR_DATA_W-1:0] data_q [N];
  rr_pkg::rr_chan_t      nxt [N];
  logic                  rply_fire;
  logic                  bad_id;

  // replay words are taken every cycle while replaying
  assign o_rply_ready = i_replay_en;
  assign rply_fire    = i_rply_valid && i_replay_en;

  // ids past the last channel name nothing
  assign bad_id     = (int'(i_rply_word.chan) >= N);
  assign o_bad_chan = rply_fire && bad_id;

  //////////////////////////////////////////////////
  // source select
  //////////////////////////////////////////////////
  // in replay the shell side is ignored entirely
  always_comb begin
    for (int c = 0; c < N; c++) begin
      if (i_replay_en) begin
        nxt[c].valid = rply_fire && (int'(i_rply_word.chan) == c);
        nxt[c].data  = i_rply_word.data;
      end else begin
        nxt[c] = i_sh_chan[c];
      end
    end
  end

  //////////////////////////////////////////////////
  // register stage toward the cl
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      valid_q <= '0;
    end else begin
      for (int c = 0; c < N; c++) begin
        valid_q[c] <= nxt[c].valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int c = 0; c < N; c++) begin
      data_q[c] <= nxt[c].data;
    end
  end

  for (genvar g = 0; g < N; g++) begin : g_cl_out
    assign o_cl_chan[g].valid = valid_q[g];
    assign o_cl_chan[g].data  = data_q[g];
  end

endmodule

// ==== rr_wrapper.sv ====
`timescale 1ns/1ps
`include "rr_wrapper_settings.svh"

module rr_wrapper (
  input  logic                      clk,
  input  logic                      rstn,
  // shell side and cl side channels
  input  rr_pkg::rr_chan_t          i_sh_chan [`RR_NUM_CHAN],
  output rr_pkg::rr_chan_t          o_cl_chan [`RR_NUM_CHAN],
  // outgoing log stream
  output logic                      o_log_valid,
  output rr_pkg::rr_log_word_t      o_log_word,
  input  logic                      i_log_ready,
  // incoming replay stream
  input  logic                      i_rply_valid,
  input  rr_pkg::rr_log_word_t      i_rply_word,
  output logic                      o_rply_ready,
  // control registers
  input  logic                      i_csr_wr,
  input  logic [`RR_CSR_ADDR_W-1:0] i_csr_addr,
  input  logic [`RR_CSR_DATA_W-1:0] i_csr_wdata,
  output logic [`RR_CSR_DATA_W-1:0] o_csr_rdata
);

  localparam int N = `RR_NUM_CHAN;

  rr_pkg::rr_mode_t     mode;
  logic [N-1:0]         ovf;
  logic [N-1:0]         almful;
  logic                 bad_chan;
  logic                 log_xfer;
  rr_pkg::rr_log_word_t entry [N];
  logic [N-1:0]         empty;
  logic [N-1:0]         pop;

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////
  rr_csrs u_csrs (
    .clk         (clk),
    .rstn        (rstn),
    .i_csr_wr    (i_csr_wr),
    .i_csr_addr  (i_csr_addr),
    .i_csr_wdata (i_csr_wdata),
    .i_ovf       (ovf),
    .i_almful    (almful),
    .i_bad_chan  (bad_chan),
    .i_log_xfer  (log_xfer),
    .o_csr_rdata (o_csr_rdata),
    .o_mode      (mode)
  );

  // shell or replay traffic into the cl
  rr_replay_decoder u_decoder (
    .clk          (clk),
    .rstn         (rstn),
    .i_sh_chan    (i_sh_chan),
    .i_replay_en  (mode.replay_en),
    .i_rply_valid (i_rply_valid),
    .i_rply_word  (i_rply_word),
    .o_rply_ready (o_rply_ready),
    .o_cl_chan    (o_cl_chan),
    .o_bad_chan   (bad_chan)
  );

  //////////////////////////////////////////////////
  // record path
  //////////////////////////////////////////////////
  // recorders watch what actually reaches the cl
  for (genvar g = 0; g < N; g++) begin : g_rec
    rr_channel_recorder #(
      .CHAN_ID (g)
    ) u_recorder (
      .clk         (clk),
      .rstn        (rstn),
      .i_cl_chan   (o_cl_chan[g]),
      .i_record_en (mode.record_en),
      .i_pop       (pop[g]),
      .o_entry     (entry[g]),
      .o_empty     (empty[g]),
      .o_almful    (almful[g]),
      .o_ovf       (ovf[g])
    );
  end

  rr_log_merger u_merger (
    .clk         (clk),
    .rstn        (rstn),
    .i_entry     (entry),
    .i_empty     (empty),
    .i_log_ready (i_log_ready),
    .o_pop       (pop),
    .o_log_valid (o_log_valid),
    .o_log_word  (o_log_word),
    .o_log_xfer  (log_xfer)
  );

endmodule

// ==== rr_wrapper_assertions.sv ====
`timescale 1ns/1ps
`include "rr_wrapper_settings.svh"

module rr_wrapper_assertions (
  input logic                      clk,
  input logic                      rstn,
  input logic                      i_csr_wr,
  input logic [`RR_CSR_ADDR_W-1:0] i_csr_addr,
  input logic [`RR_CSR_DATA_W-1:0] i_csr_wdata,
  input rr_pkg::rr_chan_t          i_cl_chan [`RR_NUM_CHAN],
  input logic                      i_log_valid,
  input rr_pkg::rr_log_word_t      i_log_word,
  input logic                      i_log_ready,
  input logic                      i_rply_ready
);

  int                      fail_cnt = 0;
  logic [`RR_NUM_CHAN-1:0] cl_valid;
  logic                    mode_wr;

  for (genvar g = 0; g < `RR_NUM_CHAN; g++) begin : g_valid
    assign cl_valid[g] = i_cl_chan[g].valid;
  end

  // mode writes seen on the csr port
  assign mode_wr = i_csr_wr && (i_csr_addr == `RR_CSR_MODE);

  //////////////////////////////////////////////////
  // stream and reset rules
  //////////////////////////////////////////////////
  // stalled log word holds until it transfers
  a_log_hold : assert property (
    @(posedge clk) disable iff (!rstn)
    (i_log_valid && !i_log_ready) |=> (i_log_valid && $stable(i_log_word))
  ) else begin
    fail_cnt++;
    $error("log word or valid changed while stalled");
  end

  // replay ready takes the replay bit (bit 1) of a mode write one cycle later
  a_rply_set : assert property (
    @(posedge clk) disable iff (!rstn)
    mode_wr |=> (i_rply_ready == $past(i_csr_wdata[1]))
  ) else begin
    fail_cnt++;
    $error("replay ready does not follow the written mode");
  end

  // between mode writes replay ready keeps its level
  a_rply_hold : assert property (
    @(posedge clk) disable iff (!rstn)
    !mode_wr |=> $stable(i_rply_ready)
  ) else begin
    fail_cnt++;
    $error("replay ready changed without a mode write");
  end

  // cl side is quiet and replay closed right after reset
  a_cl_reset : assert property (
    @(posedge clk)
    !rstn |=> ((cl_valid == '0) && !i_rply_ready)
  ) else begin
    fail_cnt++;
    $error("cl strobe or replay ready in the cycle after reset");
  end

endmodule

bind rr_wrapper rr_wrapper_assertions u_assertions (
  .clk          (clk),
  .rstn         (rstn),
  .i_csr_wr     (i_csr_wr),
  .i_csr_addr   (i_csr_addr),
  .i_csr_wdata  (i_csr_wdata),
  .i_cl_chan    (o_cl_chan),
  .i_log_valid  (o_log_valid),
  .i_log_word   (o_log_word),
  .i_log_ready  (i_log_ready),
  .i_rply_ready (o_rply_ready)
);

// ==== tb_rr_wrapper.sv ====
`timescale 1ns/1ps
`include "rr_wrapper_settings.svh"

module tb_rr_wrapper;

  localparam int N           = `RR_NUM_CHAN;
  localparam int NUM_ROWS    = 53;
  localparam int TIMEOUT_CYC = NUM_ROWS * 20 + 200;

  typedef enum logic [2:0] {OP_WR, OP_RD, OP_SH, OP_RP, OP_IDLE, OP_RDY} op_e;

  // chan doubles as csr address; expected is read data, or "logged" for strobes
  typedef struct packed {
    op_e         op;
    logic [1:0]  chan;
    logic [31:0] data;
    logic [31:0] expected;
  } row_t;

  // one predicted cl strobe or log word, due is the monitor cycle it must show up
  typedef struct packed {
    logic [`RR_CHAN_ID_W-1:0] chan;
    logic [`RR_DATA_W-1:0]    data;
    logic [31:0]              due;
  } exp_t;

  localparam row_t ROWS [NUM_ROWS] = '{
    // csr access right after reset
    '{OP_RD, 2'd0, 32'h0, 32'h0}, '{OP_RD, 2'd1, 32'h0, 32'h0}, '{OP_RD, 2'd2, 32'h0, 32'h0},
    '{OP_WR, 2'd0, 32'h3, 32'h0}, '{OP_RD, 2'd0, 32'h0, 32'h3},
    '{OP_WR, 2'd0, 32'h0, 32'h0}, '{OP_RD, 2'd0, 32'h0, 32'h0},
    // passthrough, nothing logged
    '{OP_SH, 2'd0, 32'ha1b2, 32'h0}, '{OP_SH, 2'd1, 32'hc3d4, 32'h0},
    '{OP_SH, 2'd0, 32'h0007, 32'h0}, '{OP_IDLE, 2'd0, 32'd2, 32'h0},
    // record under random back-pressure, 4 strobes per channel never overflow
    '{OP_RDY, 2'd0, 32'h1, 32'h0}, '{OP_WR, 2'd0, 32'h1, 32'h0},
    '{OP_SH, 2'd0, 32'h1001, 32'h1}, '{OP_SH, 2'd1, 32'h2001, 32'h1},
    '{OP_SH, 2'd0, 32'h1002, 32'h1}, '{OP_SH, 2'd1, 32'h2002, 32'h1},
    '{OP_SH, 2'd1, 32'h2003, 32'h1}, '{OP_SH, 2'd0, 32'h1003, 32'h1},
    '{OP_SH, 2'd0, 32'h1004, 32'h1}, '{OP_SH, 2'd1, 32'h2004, 32'h1},
    '{OP_RDY, 2'd0, 32'h2, 32'h0}, '{OP_IDLE, 2'd0, 32'd12, 32'h0},
    '{OP_RD, 2'd1, 32'h0, 32'h0}, '{OP_RD, 2'd2, 32'h0, 32'd8},
    // overflow, ch1 word parks in the output slot so fifo 0 takes exactly 4
    '{OP_RDY, 2'd0, 32'h0, 32'h0}, '{OP_SH, 2'd1, 32'h3001, 32'h1},
    '{OP_SH, 2'd0, 32'h4001, 32'h1}, '{OP_SH, 2'd0, 32'h4002, 32'h1},
    '{OP_SH, 2'd0, 32'h4003, 32'h1}, '{OP_SH, 2'd0, 32'h4004, 32'h1},
    '{OP_SH, 2'd0, 32'h4005, 32'h0}, '{OP_IDLE, 2'd0, 32'd1, 32'h0},
    '{OP_RD, 2'd1, 32'h0, 32'h9}, '{OP_WR, 2'd1, 32'h7, 32'h0}, '{OP_RD, 2'd1, 32'h0, 32'h8},
    '{OP_RDY, 2'd0, 32'h2, 32'h0}, '{OP_IDLE, 2'd0, 32'd12, 32'h0},
    '{OP_RD, 2'd1, 32'h0, 32'h0}, '{OP_RD, 2'd2, 32'h0, 32'd13},
    // replay, shell ignored and id 3 flagged
    '{OP_WR, 2'd0, 32'h2, 32'h0}, '{OP_RD, 2'd0, 32'h0, 32'h2},
    '{OP_RP, 2'd0, 32'h5a5a, 32'h0}, '{OP_RP, 2'd1, 32'h6b6b, 32'h0},
    '{OP_SH, 2'd0, 32'hdead, 32'h0}, '{OP_RP, 2'd3, 32'h7c7c, 32'h0},
    '{OP_RP, 2'd1, 32'h8d8d, 32'h0}, '{OP_IDLE, 2'd0, 32'd2, 32'h0},
    '{OP_RD, 2'd1, 32'h0, 32'h4}, '{OP_WR, 2'd1, 32'h7, 32'h0}, '{OP_RD, 2'd1, 32'h0, 32'h0},
    '{OP_WR, 2'd0, 32'h0, 32'h0}, '{OP_RD, 2'd0, 32'h0, 32'h0}
  };

  logic                      clk;
  logic                      rstn;
  rr_pkg::rr_chan_t          sh_chan [N];
  rr_pkg::rr_chan_t          cl_chan [N];
  logic                      log_valid;
  rr_pkg::rr_log_word_t      log_word;
  logic                      log_ready;
  logic                      rply_valid;
  rr_pkg::rr_log_word_t      rply_word;
  logic                      rply_ready;
  logic                      csr_wr;
  logic [`RR_CSR_ADDR_W-1:0] csr_addr;
  logic [`RR_CSR_DATA_W-1:0] csr_wdata;
  logic [`RR_CSR_DATA_W-1:0] csr_rdata;

  exp_t        cl_q [$];
  exp_t        log_q [$];
  logic [31:0] ncyc = 0;
  int          cyc_cnt = 0;
  logic [1:0]  rdy_mode;
  logic [31:0] lcg_state = 32'hd585_f56b;
  logic        rec_on;
  logic        rply_on;

  rr_wrapper dut (
    .clk          (clk),
    .rstn         (rstn),
    .i_sh_chan    (sh_chan),
    .o_cl_chan    (cl_chan),
    .o_log_valid  (log_valid),
    .o_log_word   (log_word),
    .i_log_ready  (log_ready),
    .i_rply_valid (rply_valid),
    .i_rply_word  (rply_word),
    .o_rply_ready (rply_ready),
    .i_csr_wr     (csr_wr),
    .i_csr_addr   (csr_addr),
    .i_csr_wdata  (csr_wdata),
    .o_csr_rdata  (csr_rdata)
  );

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic halt_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      halt_run($sformatf("FAIL %s: got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic write_csr(input logic [1:0] addr, input logic [31:0] d);
    @(posedge clk);
    csr_wr    <= 1'b1;
    csr_addr  <= addr;
    csr_wdata <= d;
    @(posedge clk);
    csr_wr <= 1'b0;
    // mode register is live from this edge on
    if (addr == `RR_CSR_MODE) begin
      rec_on  = d[0];
      rply_on = d[1];
    end
  endtask

  task automatic read_csr(input logic [1:0] addr, input logic [31:0] exp);
    @(posedge clk);
    csr_addr <= addr;
    @(posedge clk);
    @(negedge clk);
    check_equal("o_csr_rdata", csr_rdata, exp);
  endtask

  // one-cycle shell strobe, lands on the cl two monitor cycles later
  task automatic shell_strobe(input logic [1:0] c, input logic [15:0] d, input logic logged);
    @(posedge clk);
    sh_chan[c].valid <= 1'b1;
    sh_chan[c].data  <= d;
    if (!rply_on) begin
      cl_q.push_back('{chan: c, data: d, due: ncyc + 32'd2});
      if (rec_on && logged) begin
        log_q.push_back('{chan: c, data: d, due: 32'd0});
      end
    end
    @(posedge clk);
    sh_chan[c].valid <= 1'b0;
  endtask

  task automatic replay_word(input logic [1:0] id, input logic [15:0] d);
    logic rdy;
    @(posedge clk);
    rply_valid     <= 1'b1;
    rply_word.chan <= id;
    rply_word.data <= d;
    rdy = 1'b0;
    // hold the word until the handshake, timeout guards the loop
    while (!rdy) begin
      @(negedge clk);
      rdy = rply_ready;
      @(posedge clk);
    end
    rply_valid <= 1'b0;
    if (int'(id) < N) begin
      cl_q.push_back('{chan: id, data: d, due: ncyc + 32'd1});
    end
  endtask

  //////////////////////////////////////////////////
  // clock, back-pressure and timeout
  //////////////////////////////////////////////////
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // 0 holds ready low, 1 takes it from the lcg, 2 holds it high
  always @(posedge clk) begin
    if (rdy_mode == 2'd1) begin
      lcg_state = lcg_next(lcg_state);
      log_ready <= lcg_state[31];
    end else begin
      log_ready <= (rdy_mode == 2'd2);
    end
  end

  always @(posedge clk) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt > TIMEOUT_CYC) begin
      halt_run($sformatf("timeout after %0d cycles without finishing the table", cyc_cnt));
    end
    if (dut.u_assertions.fail_cnt != 0) begin
      halt_run("a bound assertion on the DUT ports fired");
    end
  end

  //////////////////////////////////////////////////
  // scoreboard, sampled mid-cycle
  //////////////////////////////////////////////////
  always @(negedge clk) begin : monitor
    int hit;
    ncyc = ncyc + 32'd1;
    for (int c = 0; c < N; c++) begin
      hit = -1;
      for (int i = 0; i < cl_q.size(); i++) begin
        if (hit < 0 && int'(cl_q[i].chan) == c) begin
          hit = i;
        end
      end
      if (hit >= 0 && cl_q[hit].due == ncyc) begin
        check_equal("o_cl_chan.valid", 32'(cl_chan[c].valid), 32'h1);
        check_equal("o_cl_chan.data", 32'(cl_chan[c].data), 32'(cl_q[hit].data));
        cl_q.delete(hit);
      end else if (cl_chan[c].valid) begin
        halt_run($sformatf("strobe on CL channel %0d that no stimulus called for", c));
      end
    end
    // per-channel order only, the merger may interleave channels freely
    if (log_valid && log_ready) begin
      hit = -1;
      for (int i = 0; i < log_q.size(); i++) begin
        if (hit < 0 && log_q[i].chan == log_word.chan) begin
          hit = i;
        end
      end
      if (hit < 0) begin
        halt_run("log word transferred with no matching recorded strobe");
      end else begin
        check_equal("o_log_word.data", 32'(log_word.data), 32'(log_q[hit].data));
        log_q.delete(hit);
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////
  initial begin
    row_t row;
    rstn       = 1'b0;
    rdy_mode   = 2'd2;
    log_ready  = 1'b1;
    rply_valid = 1'b0;
    rply_word  = '0;
    csr_wr     = 1'b0;
    csr_addr   = '0;
    csr_wdata  = '0;
    rec_on     = 1'b0;
    rply_on    = 1'b0;
    for (int c = 0; c < N; c++) begin
      sh_chan[c] = '0;
    end
    repeat (5) @(posedge clk);
    rstn <= 1'b1;

    for (int r = 0; r < NUM_ROWS; r++) begin
      row = ROWS[r];
      case (row.op)
        OP_WR:   write_csr(row.chan, row.data);
        OP_RD:   read_csr(row.chan, row.expected);
        OP_SH:   shell_strobe(row.chan, row.data[15:0], row.expected[0]);
        OP_RP:   replay_word(row.chan, row.data[15:0]);
        OP_IDLE: repeat (row.data) @(posedge clk);
        OP_RDY: begin
          @(posedge clk);
          rdy_mode <= row.data[1:0];
        end
        default: halt_run("unknown op in the stimulus table");
      endcase
    end

    // everything predicted must have come out
    while (cl_q.size() != 0 || log_q.size() != 0) begin
      @(posedge clk);
    end
    @(posedge clk);
    if (dut.u_assertions.fail_cnt != 0) begin
      halt_run("a bound assertion on the DUT ports fired");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

// ==== rr_wrapper.f ====
+incdir+.
rr_pkg.sv
rr_csrs.sv
rr_channel_recorder.sv
rr_log_merger.sv
rr_replay_decoder.sv
rr_wrapper.sv
rr_wrapper_assertions.sv
tb_rr_wrapper.sv

// ==== run.sh ====
#!/bin/sh
# build and run the rr_wrapper testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_rr_wrapper

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rr_wrapper \
  -f rr_wrapper.f \
  -o "$BIN"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# let bound assertions reach the testbench instead of stopping at the first one
./obj_dir/"$BIN" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Test passed$" "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "pass line not found in $LOG"
  exit 1
fi
